//--- run.sh
#!/bin/sh
# Build and run the board pin harness testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_top -f src.f \
  -o sim_tb > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
  echo "build failed, see build.log"
  exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "ALL TESTS PASSED" sim.log; then
  exit 0
fi
exit 1

//--- source/board_pins_top.sv
// Board pin harness top level.
// Takes the system pin vectors as plain ports, resolves the I2C and SPI
// lines, routes the read-back vectors and monitors the CHERI error lines.

`timescale 1ns/1ps

module board_pins_top (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  // System pin vectors.
  input  board_pkg::out_pins_t              out_to_pins_i,
  input  board_pkg::inout_pins_t            inout_to_pins_i,
  input  board_pkg::inout_pins_t            inout_to_pins_en_i,
  // I2C device models.
  input  logic [board_pkg::I2C_BUSES-1:0]   i2c_dev_scl_i,
  input  logic [board_pkg::I2C_BUSES-1:0]   i2c_dev_sda_i,
  output logic [board_pkg::I2C_BUSES-1:0]   i2c_scl_o,
  output logic [board_pkg::I2C_BUSES-1:0]   i2c_sda_o,
  // PMOD1 SPI flash.
  output logic [board_pkg::SPI_OUTS-1:0]    spi_o,
  input  logic                              spi_cipo_i,
  // System UART.
  input  logic                              uart_rx_i,
  output logic                              uart_tx_o,
  // RS485 transceiver.
  input  logic                              rs485_tx_en_i,
  input  logic                              rs485_rx_en_i,
  input  logic                              rs485_ro_i,
  output logic                              rs485_line_o,
  // CHERI error lines.
  input  board_pkg::cheri_err_t             cheri_err_i,
  // Vectors read back by the system.
  output board_pkg::in_pins_t               in_from_pins_o,
  output board_pkg::inout_pins_t            inout_from_pins_o,
  // Error reporting.
  output board_pkg::cheri_err_t             errored_o,
  output logic                              new_err_o,
  output logic [board_pkg::CHERI_IDX_W-1:0] new_err_idx_o,
  output logic [board_pkg::CHERI_CNT_W-1:0] err_count_o
);

  pin_if pins ();

  // System side of the interface.
  assign pins.out_to_pins      = out_to_pins_i;
  assign pins.inout_to_pins    = inout_to_pins_i;
  assign pins.inout_to_pins_en = inout_to_pins_en_i;

  od_bus_resolver u_od_bus_resolver (
    .pins          (pins.resolver),
    .i2c_dev_scl_i (i2c_dev_scl_i),
    .i2c_dev_sda_i (i2c_dev_sda_i),
    .i2c_scl_o     (i2c_scl_o),
    .i2c_sda_o     (i2c_sda_o),
    .spi_o         (spi_o)
  );

  pin_router u_pin_router (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .pins              (pins.router),
    .uart_rx_i         (uart_rx_i),
    .uart_tx_o         (uart_tx_o),
    .rs485_tx_en_i     (rs485_tx_en_i),
    .rs485_rx_en_i     (rs485_rx_en_i),
    .rs485_ro_i        (rs485_ro_i),
    .rs485_line_o      (rs485_line_o),
    .spi_cipo_i        (spi_cipo_i),
    .in_from_pins_o    (in_from_pins_o),
    .inout_from_pins_o (inout_from_pins_o)
  );

  cheri_err_monitor u_cheri_err_monitor (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .cheri_err_i   (cheri_err_i),
    .errored_o     (errored_o),
    .new_err_o     (new_err_o),
    .new_err_idx_o (new_err_idx_o),
    .err_count_o   (err_count_o)
  );

endmodule

//--- source/board_pkg.sv
// Board pin package.
// Pin-vector widths, named pin indices and bus counts for the board harness,
// plus the CHERI error-line widths used by the error monitor.

package board_pkg;

  // Widths of the system pin vectors.
  localparam int unsigned OUT_PIN_W   = 8;
  localparam int unsigned IN_PIN_W    = 4;
  localparam int unsigned INOUT_PIN_W = 16;

  // Modelled buses and ports.
  localparam int unsigned I2C_BUSES  = 3;
  localparam int unsigned SPI_OUTS   = 3;
  localparam int unsigned LOOPBACK_W = 5;

  // CHERI error reporting.
  localparam int unsigned CHERI_ERR_W = 9;
  localparam int unsigned CHERI_IDX_W = 4;
  localparam int unsigned CHERI_CNT_W = 4;

  // Output pin indices.
  localparam int unsigned OUT_PIN_SER0_TX  = 0;
  localparam int unsigned OUT_PIN_RS485_TX = 1;
  localparam int unsigned OUT_PIN_MB4      = 2;
  localparam int unsigned OUT_PIN_MB7      = 3;
  localparam int unsigned OUT_PIN_MB10     = 4;

  // Input pin indices.
  localparam int unsigned IN_PIN_SER0_RX  = 0;
  localparam int unsigned IN_PIN_RS485_RX = 1;
  localparam int unsigned IN_PIN_MB3      = 2;
  localparam int unsigned IN_PIN_MB8      = 3;

  // Bidirectional pin indices.
  // QWIIC1 bus, bus 0.
  localparam int unsigned INOUT_PIN_SCL1       = 0;
  localparam int unsigned INOUT_PIN_SDA1       = 1;
  // RPi HAT ID bus, bus 1.
  localparam int unsigned INOUT_PIN_RPH_G0     = 2;
  localparam int unsigned INOUT_PIN_RPH_G1     = 3;
  // RPi GPIO2/3 bus, bus 2.
  localparam int unsigned INOUT_PIN_RPH_G2_SDA = 4;
  localparam int unsigned INOUT_PIN_RPH_G3_SCL = 5;
  // PMOD1 SPI flash.
  localparam int unsigned INOUT_PIN_PMOD1_1    = 6;
  localparam int unsigned INOUT_PIN_PMOD1_2    = 7;
  localparam int unsigned INOUT_PIN_PMOD1_3    = 8;
  localparam int unsigned INOUT_PIN_PMOD1_4    = 9;
  // Loopback pins.
  localparam int unsigned INOUT_PIN_PMOD0_1    = 10;
  localparam int unsigned INOUT_PIN_PMOD0_8    = 11;
  localparam int unsigned INOUT_PIN_PMOD0_10   = 12;
  localparam int unsigned INOUT_PIN_PMODC_1    = 13;
  // Unmodelled bus, pulled up on the board.
  localparam int unsigned INOUT_PIN_SCL0       = 14;
  localparam int unsigned INOUT_PIN_SDA0       = 15;

  typedef logic [1:0]             i2c_bus_idx_t;
  typedef logic [OUT_PIN_W-1:0]   out_pins_t;
  typedef logic [IN_PIN_W-1:0]    in_pins_t;
  typedef logic [INOUT_PIN_W-1:0] inout_pins_t;
  typedef logic [CHERI_ERR_W-1:0] cheri_err_t;

  // SCL pin of each modelled bus.
  function automatic int unsigned i2c_scl_pin(i2c_bus_idx_t bus);
    case (bus)
      2'd0:    return INOUT_PIN_SCL1;
      2'd1:    return INOUT_PIN_RPH_G1;
      default: return INOUT_PIN_RPH_G3_SCL;
    endcase
  endfunction

  // SDA pin of each modelled bus.
  function automatic int unsigned i2c_sda_pin(i2c_bus_idx_t bus);
    case (bus)
      2'd0:    return INOUT_PIN_SDA1;
      2'd1:    return INOUT_PIN_RPH_G0;
      default: return INOUT_PIN_RPH_G2_SDA;
    endcase
  endfunction

endpackage

//--- source/cheri_err_monitor.sv
// CHERI error monitor.
// Keeps a sticky set of CHERI error lines, pulses on each first occurrence
// and tracks the lowest new index and the count of distinct errors.

`timescale 1ns/1ps

module cheri_err_monitor (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  board_pkg::cheri_err_t             cheri_err_i,
  output board_pkg::cheri_err_t             errored_o,
  output logic                              new_err_o,
  output logic [board_pkg::CHERI_IDX_W-1:0] new_err_idx_o,
  output logic [board_pkg::CHERI_CNT_W-1:0] err_count_o
);
  import board_pkg::*;

  cheri_err_t             errored_q;
  cheri_err_t             new_bits;
  logic                   new_err_q;
  logic [CHERI_IDX_W-1:0] new_idx;
  logic [CHERI_IDX_W-1:0] new_idx_q;
  logic [CHERI_CNT_W-1:0] new_cnt;
  logic [CHERI_CNT_W-1:0] count_q;

  // The lines are modulated to drive LEDs.
  // Only bits not yet sticky count as new.
  assign new_bits = cheri_err_i & ~errored_q;

  always_comb begin
    new_idx = '0;
    new_cnt = '0;
    // Walk down so the lowest set bit wins.
    for (int i = CHERI_ERR_W - 1; i >= 0; i--) begin
      if (new_bits[i]) begin
        new_idx = CHERI_IDX_W'(i);
      end
    end
    for (int i = 0; i < CHERI_ERR_W; i++) begin
      new_cnt = new_cnt + CHERI_CNT_W'(new_bits[i]);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      errored_q <= '0;
      new_err_q <= 1'b0;
      new_idx_q <= '0;
      count_q   <= '0;
    end else begin
      errored_q <= errored_q | cheri_err_i;
      // High for the cycle after any first occurrence.
      new_err_q <= |new_bits;
      if (|new_bits) begin
        new_idx_q <= new_idx;
        count_q   <= count_q + new_cnt;
      end
    end
  end

  assign errored_o     = errored_q;
  assign new_err_o     = new_err_q;
  assign new_err_idx_o = new_idx_q;
  assign err_count_o   = count_q;

endmodule

//--- source/od_bus_resolver.sv
// Open-drain bus resolver.
// Forms the I2C levels seen by the devices and by the controller, and
// drives the PMOD1 SPI flash outputs high when they are not enabled.

`timescale 1ns/1ps

module od_bus_resolver (
  pin_if.resolver                     pins,
  // Levels driven by the device models.
  input  logic [board_pkg::I2C_BUSES-1:0] i2c_dev_scl_i,
  input  logic [board_pkg::I2C_BUSES-1:0] i2c_dev_sda_i,
  // Controller levels toward the device models.
  output logic [board_pkg::I2C_BUSES-1:0] i2c_scl_o,
  output logic [board_pkg::I2C_BUSES-1:0] i2c_sda_o,
  // Bit 0 chip select, bit 1 COPI, bit 2 clock.
  output logic [board_pkg::SPI_OUTS-1:0]  spi_o
);
  import board_pkg::*;

  localparam int unsigned pin_idx_w = $clog2(INOUT_PIN_W);

  // PMOD1 pins in spi_o bit order.
  localparam logic [SPI_OUTS-1:0][pin_idx_w-1:0] spi_pins = {
    pin_idx_w'(INOUT_PIN_PMOD1_4),
    pin_idx_w'(INOUT_PIN_PMOD1_2),
    pin_idx_w'(INOUT_PIN_PMOD1_1)
  };

  for (genvar b = 0; b < I2C_BUSES; b++) begin : g_bus
    localparam int unsigned scl_idx = i2c_scl_pin(i2c_bus_idx_t'(b));
    localparam int unsigned sda_idx = i2c_sda_pin(i2c_bus_idx_t'(b));

    // Released lines float high through the bus pull-ups.
    assign i2c_scl_o[b] = pins.inout_to_pins_en[scl_idx] ? pins.inout_to_pins[scl_idx] : 1'b1;
    assign i2c_sda_o[b] = pins.inout_to_pins_en[sda_idx] ? pins.inout_to_pins[sda_idx] : 1'b1;

    // Wired-AND of both sides.
    // The controller must see its own traffic on the real bus, or it reports contention.
    assign pins.i2c_scl_in[b] = i2c_scl_o[b] & i2c_dev_scl_i[b];
    assign pins.i2c_sda_in[b] = i2c_sda_o[b] & i2c_dev_sda_i[b];
  end

  for (genvar s = 0; s < SPI_OUTS; s++) begin : g_spi
    // Chip select is active low, so idle-high keeps the flash deselected.
    assign spi_o[s] = pins.inout_to_pins_en[spi_pins[s]] ? pins.inout_to_pins[spi_pins[s]]
                                                         : 1'b1;
  end

endmodule

//--- source/pin_if.sv
// System pin interface.
// Carries the system's pin vectors and the resolved I2C levels between
// the bus resolver and the pin router.

`timescale 1ns/1ps

interface pin_if;
  import board_pkg::*;

  // Driven from the top-level ports.
  out_pins_t   out_to_pins;
  inout_pins_t inout_to_pins;
  inout_pins_t inout_to_pins_en;

  // Resolved bus levels, as the controller sees them.
  logic [I2C_BUSES-1:0] i2c_scl_in;
  logic [I2C_BUSES-1:0] i2c_sda_in;

  // Bus resolver side.
  modport resolver (
    input  inout_to_pins,
    input  inout_to_pins_en,
    output i2c_scl_in,
    output i2c_sda_in
  );

  // Input vector assembly side.
  modport router (
    input out_to_pins,
    input inout_to_pins,
    input i2c_scl_in,
    input i2c_sda_in
  );

endinterface

//--- source/pin_router.sv
// Pin router.
// Builds the input pin vectors read by the system from the resolved buses,
// UART, RS485, SPI CIPO, pull-ups and a one-cycle loopback stage.

`timescale 1ns/1ps

module pin_router (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  pin_if.router                  pins,
  // System UART.
  input  logic                   uart_rx_i,
  output logic                   uart_tx_o,
  // RS485 transceiver.
  input  logic                   rs485_tx_en_i,
  input  logic                   rs485_rx_en_i,
  input  logic                   rs485_ro_i,
  output logic                   rs485_line_o,
  // PMOD1 flash data out.
  input  logic                   spi_cipo_i,
  // Vectors read back by the system.
  output board_pkg::in_pins_t    in_from_pins_o,
  output board_pkg::inout_pins_t inout_from_pins_o
);
  import board_pkg::*;

  logic [LOOPBACK_W-1:0] loopback_d;
  logic [LOOPBACK_W-1:0] loopback_q;

  // Loopback sources.
  // Bit 0 mikroBUS COPI to CIPO, bit 1 mikroBUS TX to RX, bit 2 PWM to PMOD0.1.
  assign loopback_d[0] = pins.out_to_pins[OUT_PIN_MB4];
  assign loopback_d[1] = pins.out_to_pins[OUT_PIN_MB7];
  assign loopback_d[2] = pins.out_to_pins[OUT_PIN_MB10];
  // PMOD0 8 to 10, and PMODC 1 back onto itself for pin-change testing.
  assign loopback_d[3] = pins.inout_to_pins[INOUT_PIN_PMOD0_8];
  assign loopback_d[4] = pins.inout_to_pins[INOUT_PIN_PMODC_1];

  // One register stage.
  // Breaks the net-level loop from the output vectors back to the input vectors.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      loopback_q <= '0;
    end else begin
      loopback_q <= loopback_d;
    end
  end

  // UART transmit goes straight to the line.
  assign uart_tx_o = pins.out_to_pins[OUT_PIN_SER0_TX];

  // Transceiver driver off leaves the line idle.
  assign rs485_line_o = rs485_tx_en_i ? pins.out_to_pins[OUT_PIN_RS485_TX] : 1'b1;

  always_comb begin
    in_from_pins_o = '1;
    in_from_pins_o[IN_PIN_SER0_RX]  = uart_rx_i;
    // Receiver disabled reads as idle.
    in_from_pins_o[IN_PIN_RS485_RX] = rs485_rx_en_i ? rs485_ro_i : 1'b1;
    in_from_pins_o[IN_PIN_MB3]      = loopback_q[0];
    in_from_pins_o[IN_PIN_MB8]      = loopback_q[1];
  end

  always_comb begin
    // Pull-ups on every pin without a model, SCL0 and SDA0 included.
    inout_from_pins_o = '1;
    for (int unsigned b = 0; b < I2C_BUSES; b++) begin
      inout_from_pins_o[i2c_scl_pin(i2c_bus_idx_t'(b))] = pins.i2c_scl_in[b];
      inout_from_pins_o[i2c_sda_pin(i2c_bus_idx_t'(b))] = pins.i2c_sda_in[b];
    end
    inout_from_pins_o[INOUT_PIN_PMOD1_3]  = spi_cipo_i;
    inout_from_pins_o[INOUT_PIN_PMOD0_1]  = loopback_q[2];
    inout_from_pins_o[INOUT_PIN_PMOD0_10] = loopback_q[3];
    inout_from_pins_o[INOUT_PIN_PMODC_1]  = loopback_q[4];
    // Bus pull-ups hold the unmodelled pair high.
    inout_from_pins_o[INOUT_PIN_SCL0]     = 1'b1;
    inout_from_pins_o[INOUT_PIN_SDA0]     = 1'b1;
  end

endmodule

//--- src.f
source/board_pkg.sv
source/pin_if.sv
source/od_bus_resolver.sv
source/pin_router.sv
source/cheri_err_monitor.sv
source/board_pins_top.sv
tb/board_chk.sv
tb/tb_monitor.sv
tb/tb_top.sv

//--- tb/board_chk.sv
// Bound assertions for the CHERI error monitor and the loopback stage.

`timescale 1ns/1ps

module board_chk #(
  parameter bit cheri_side = 1'b1
) (
  input logic clk_i,
  input logic rst_ni,
  input board_pkg::cheri_err_t errored,
  input logic new_err,
  input logic [board_pkg::CHERI_CNT_W-1:0] cnt,
  input logic [board_pkg::LOOPBACK_W-1:0] lb_d,
  input logic [board_pkg::LOOPBACK_W-1:0] lb_q
);

  if (cheri_side) begin : g_cheri
    // The pulse marks exactly the cycles where the sticky set grew.
    a_new_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
      $past(rst_ni) |-> new_err == (errored != $past(errored))) else $error("new_err_o");
    a_sticky: assert property (@(posedge clk_i) disable iff (!rst_ni)
      $past(rst_ni) |-> (errored & $past(errored)) == $past(errored)) else $error("errored_o");
    a_count: assert property (@(posedge clk_i) disable iff (!rst_ni)
      32'(cnt) == $countones(errored)) else $error("err_count_o");
  end else begin : g_loop
    // Destination bits of the read-back vectors follow their sources by one cycle.
    a_loopback: assert property (@(posedge clk_i) disable iff (!rst_ni)
      $past(rst_ni) |-> lb_q == $past(lb_d)) else $error("loopback");
  end

endmodule

bind cheri_err_monitor board_chk #(.cheri_side(1'b1)) u_chk (
  .clk_i (clk_i), .rst_ni (rst_ni), .errored (errored_q), .new_err (new_err_q),
  .cnt (count_q), .lb_d (5'b0), .lb_q (5'b0)
);

bind pin_router board_chk #(.cheri_side(1'b0)) u_chk (
  .clk_i   (clk_i),
  .rst_ni  (rst_ni),
  .errored (9'b0),
  .new_err (1'b0),
  .cnt     (4'b0),
  .lb_d    (loopback_d),
  .lb_q    ({inout_from_pins_o[board_pkg::INOUT_PIN_PMODC_1],
             inout_from_pins_o[board_pkg::INOUT_PIN_PMOD0_10],
             inout_from_pins_o[board_pkg::INOUT_PIN_PMOD0_1],
             in_from_pins_o[board_pkg::IN_PIN_MB8],
             in_from_pins_o[board_pkg::IN_PIN_MB3]})
);

//--- tb/tb_monitor.sv
// Testbench reference model and checker.
// Mirrors the pin rules and the error monitor, compares on each falling edge.

`timescale 1ns/1ps

module tb_monitor (
  input logic                              clk_i,
  input logic                              rst_ni,
  input board_pkg::out_pins_t              out_to_pins,
  input board_pkg::inout_pins_t            inout_to_pins,
  input board_pkg::inout_pins_t            inout_to_pins_en,
  input logic [board_pkg::I2C_BUSES-1:0]   i2c_dev_scl,
  input logic [board_pkg::I2C_BUSES-1:0]   i2c_dev_sda,
  input logic [board_pkg::I2C_BUSES-1:0]   i2c_scl,
  input logic [board_pkg::I2C_BUSES-1:0]   i2c_sda,
  input logic [board_pkg::SPI_OUTS-1:0]    spi,
  input logic                              spi_cipo,
  input logic                              uart_rx,
  input logic                              uart_tx,
  input logic                              rs485_tx_en,
  input logic                              rs485_rx_en,
  input logic                              rs485_ro,
  input logic                              rs485_line,
  input board_pkg::cheri_err_t             cheri_err,
  input board_pkg::in_pins_t               in_from_pins,
  input board_pkg::inout_pins_t            inout_from_pins,
  input board_pkg::cheri_err_t             errored,
  input logic                              new_err,
  input logic [board_pkg::CHERI_IDX_W-1:0] new_err_idx,
  input logic [board_pkg::CHERI_CNT_W-1:0] err_count
);
  import board_pkg::*;

  localparam int unsigned scl_pin [I2C_BUSES] =
    '{INOUT_PIN_SCL1, INOUT_PIN_RPH_G1, INOUT_PIN_RPH_G3_SCL};
  localparam int unsigned sda_pin [I2C_BUSES] =
    '{INOUT_PIN_SDA1, INOUT_PIN_RPH_G0, INOUT_PIN_RPH_G2_SDA};
  localparam int unsigned spi_pin [SPI_OUTS] =
    '{INOUT_PIN_PMOD1_1, INOUT_PIN_PMOD1_2, INOUT_PIN_PMOD1_4};

  int test_errs = 0;
  int total_errs = 0;
  int tests_run = 0;
  int tests_failed = 0;
  logic [LOOPBACK_W-1:0] lb_q = '0;
  cheri_err_t m_err = '0;
  cheri_err_t newb;
  logic found;
  logic m_new = 1'b0;
  logic [CHERI_IDX_W-1:0] m_idx = '0;
  logic [CHERI_CNT_W-1:0] m_cnt = '0;
  logic [I2C_BUSES-1:0] e_scl;
  logic [I2C_BUSES-1:0] e_sda;
  logic [SPI_OUTS-1:0] e_spi;
  in_pins_t e_in;
  inout_pins_t e_inout;

  // A released line floats high.
  function automatic logic driven(input logic en, input logic v);
    return en ? v : 1'b1;
  endfunction

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("error %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
      test_errs++;
    end
  endtask

  // State model, updated on the same edges as the DUT.
  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lb_q = '0;
      m_err = '0;
      m_new = 1'b0;
      m_idx = '0;
      m_cnt = '0;
    end else begin
      newb = cheri_err & ~m_err;
      m_new = |newb;
      if (m_new) begin
        // First new line counting up from bit 0.
        found = 1'b0;
        for (int i = 0; i < CHERI_ERR_W; i++) begin
          if (newb[i] && !found) begin
            m_idx = CHERI_IDX_W'(i);
            found = 1'b1;
          end
        end
      end
      m_err = m_err | cheri_err;
      // Distinct errors seen so far.
      m_cnt = CHERI_CNT_W'($countones(m_err));
      lb_q = {inout_to_pins[INOUT_PIN_PMODC_1], inout_to_pins[INOUT_PIN_PMOD0_8],
              out_to_pins[OUT_PIN_MB10], out_to_pins[OUT_PIN_MB7], out_to_pins[OUT_PIN_MB4]};
    end
  end

  // Outputs are settled half a cycle after the inputs change.
  always @(negedge clk_i) begin
    e_inout = '1;
    for (int b = 0; b < I2C_BUSES; b++) begin
      e_scl[b] = driven(inout_to_pins_en[scl_pin[b]], inout_to_pins[scl_pin[b]]);
      e_sda[b] = driven(inout_to_pins_en[sda_pin[b]], inout_to_pins[sda_pin[b]]);
      e_inout[scl_pin[b]] = e_scl[b] & i2c_dev_scl[b];
      e_inout[sda_pin[b]] = e_sda[b] & i2c_dev_sda[b];
    end
    for (int s = 0; s < SPI_OUTS; s++) begin
      e_spi[s] = driven(inout_to_pins_en[spi_pin[s]], inout_to_pins[spi_pin[s]]);
    end
    e_inout[INOUT_PIN_PMOD1_3] = spi_cipo;
    e_inout[INOUT_PIN_PMOD0_1] = lb_q[2];
    e_inout[INOUT_PIN_PMOD0_10] = lb_q[3];
    e_inout[INOUT_PIN_PMODC_1] = lb_q[4];
    e_in = {lb_q[1], lb_q[0], driven(rs485_rx_en, rs485_ro), uart_rx};
    check("i2c_scl_o", 32'(i2c_scl), 32'(e_scl));
    check("i2c_sda_o", 32'(i2c_sda), 32'(e_sda));
    check("spi_o", 32'(spi), 32'(e_spi));
    check("uart_tx_o", 32'(uart_tx), 32'(out_to_pins[OUT_PIN_SER0_TX]));
    check("rs485_line_o", 32'(rs485_line),
          32'(driven(rs485_tx_en, out_to_pins[OUT_PIN_RS485_TX])));
    check("in_from_pins_o", 32'(in_from_pins), 32'(e_in));
    check("inout_from_pins_o", 32'(inout_from_pins), 32'(e_inout));
    check("errored_o", 32'(errored), 32'(m_err));
    check("new_err_o", 32'(new_err), 32'(m_new));
    check("new_err_idx_o", 32'(new_err_idx), 32'(m_idx));
    check("err_count_o", 32'(err_count), 32'(m_cnt));
  end

  // A wait that timed out counts against the running test.
  task automatic record_failure();
    test_errs++;
  endtask

  task automatic end_test(input string name);
    tests_run++;
    total_errs += test_errs;
    if (test_errs == 0) begin
      $display("test %s passed", name);
    end else begin
      $display("test %s failed with %0d errors", name, test_errs);
      tests_failed++;
    end
    test_errs = 0;
  endtask

  task automatic summary();
    $display("tests run %0d, tests failed %0d, mismatches %0d",
             tests_run, tests_failed, total_errs);
  endtask

endmodule

//--- tb/tb_top.sv
// Board pin harness testbench top.
// Drives the DUT with LFSR random stimulus and steps through the tests.

`timescale 1ns/1ps

module tb_top;
  import board_pkg::*;

  logic clk_i = 1'b0;
  logic rst_ni;
  out_pins_t out_to_pins;
  inout_pins_t inout_to_pins;
  inout_pins_t inout_to_pins_en;
  logic [I2C_BUSES-1:0] i2c_dev_scl;
  logic [I2C_BUSES-1:0] i2c_dev_sda;
  logic [I2C_BUSES-1:0] i2c_scl;
  logic [I2C_BUSES-1:0] i2c_sda;
  logic [SPI_OUTS-1:0] spi;
  logic spi_cipo;
  logic uart_rx;
  logic uart_tx;
  logic rs485_tx_en;
  logic rs485_rx_en;
  logic rs485_ro;
  logic rs485_line;
  cheri_err_t cheri_err;
  in_pins_t in_from_pins;
  inout_pins_t inout_from_pins;
  cheri_err_t errored;
  logic new_err;
  logic [CHERI_IDX_W-1:0] new_err_idx;
  logic [CHERI_CNT_W-1:0] err_count;
  logic [31:0] lfsr_state = 32'h7a372c26;

  // 4 ns period.
  always #2 clk_i = ~clk_i;

  board_pins_top DUT (
    .clk_i (clk_i), .rst_ni (rst_ni),
    .out_to_pins_i (out_to_pins), .inout_to_pins_i (inout_to_pins),
    .inout_to_pins_en_i (inout_to_pins_en),
    .i2c_dev_scl_i (i2c_dev_scl), .i2c_dev_sda_i (i2c_dev_sda),
    .i2c_scl_o (i2c_scl), .i2c_sda_o (i2c_sda),
    .spi_o (spi), .spi_cipo_i (spi_cipo),
    .uart_rx_i (uart_rx), .uart_tx_o (uart_tx),
    .rs485_tx_en_i (rs485_tx_en), .rs485_rx_en_i (rs485_rx_en),
    .rs485_ro_i (rs485_ro), .rs485_line_o (rs485_line),
    .cheri_err_i (cheri_err),
    .in_from_pins_o (in_from_pins), .inout_from_pins_o (inout_from_pins),
    .errored_o (errored), .new_err_o (new_err),
    .new_err_idx_o (new_err_idx), .err_count_o (err_count)
  );

  tb_monitor u_mon (
    .clk_i (clk_i), .rst_ni (rst_ni),
    .out_to_pins (out_to_pins), .inout_to_pins (inout_to_pins),
    .inout_to_pins_en (inout_to_pins_en),
    .i2c_dev_scl (i2c_dev_scl), .i2c_dev_sda (i2c_dev_sda),
    .i2c_scl (i2c_scl), .i2c_sda (i2c_sda), .spi (spi), .spi_cipo (spi_cipo),
    .uart_rx (uart_rx), .uart_tx (uart_tx),
    .rs485_tx_en (rs485_tx_en), .rs485_rx_en (rs485_rx_en),
    .rs485_ro (rs485_ro), .rs485_line (rs485_line), .cheri_err (cheri_err),
    .in_from_pins (in_from_pins), .inout_from_pins (inout_from_pins),
    .errored (errored), .new_err (new_err),
    .new_err_idx (new_err_idx), .err_count (err_count)
  );

  // Fibonacci LFSR, taps 32, 22, 2 and 1.
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // One LFSR step per bit taken.
  task automatic draw_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
  endtask

  // New random values on every DUT input at the next rising edge.
  task automatic drive_random(input bit with_cheri);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    @(posedge clk_i);
    draw_bits(8, a);
    out_to_pins <= a[7:0];
    draw_bits(16, a);
    inout_to_pins <= a[15:0];
    draw_bits(16, a);
    inout_to_pins_en <= a[15:0];
    draw_bits(6, a);
    i2c_dev_scl <= a[2:0];
    i2c_dev_sda <= a[5:3];
    draw_bits(5, a);
    spi_cipo    <= a[0];
    uart_rx     <= a[1];
    rs485_tx_en <= a[2];
    rs485_rx_en <= a[3];
    rs485_ro    <= a[4];
    // Sparse pulses, so bits repeat and toggle like LED modulation.
    draw_bits(9, a);
    draw_bits(9, b);
    draw_bits(9, c);
    cheri_err <= with_cheri ? (a[8:0] & b[8:0] & c[8:0]) : '0;
  endtask

  // Waits for the first new-error pulse, then clears the error lines.
  task automatic wait_new_err(input int max_cycles);
    bit seen;
    seen = 1'b0;
    for (int i = 0; i < max_cycles && !seen; i++) begin
      @(posedge clk_i);
      seen = new_err;
    end
    if (!seen) begin
      $display("timeout: new_err_o never rose after a new error line");
      u_mon.record_failure();
    end
    cheri_err <= '0;
  endtask

  // Watchdog for the whole run.
  initial begin
    for (int i = 0; i < 5000; i++) begin
      @(posedge clk_i);
    end
    $display("timeout: the test sequence did not finish");
    $display("SOME TESTS FAILED");
    $finish;
  end

  initial begin
    rst_ni = 1'b1;
    out_to_pins = '0;
    inout_to_pins = '0;
    inout_to_pins_en = '0;
    i2c_dev_scl = '1;
    i2c_dev_sda = '1;
    spi_cipo = 1'b0;
    uart_rx = 1'b1;
    rs485_tx_en = 1'b0;
    rs485_rx_en = 1'b0;
    rs485_ro = 1'b1;
    cheri_err = '0;
    @(posedge clk_i);
    rst_ni <= 1'b0;
    repeat (5) @(posedge clk_i);
    rst_ni <= 1'b1;
    repeat (3) @(posedge clk_i);
    u_mon.end_test("reset_state");
    repeat (200) drive_random(1'b0);
    u_mon.end_test("open_drain_spi");
    repeat (100) drive_random(1'b0);
    u_mon.end_test("loopback");
    repeat (100) drive_random(1'b0);
    u_mon.end_test("uart_rs485");
    @(posedge clk_i);
    cheri_err <= 9'h010;
    wait_new_err(20);
    repeat (300) drive_random(1'b1);
    u_mon.end_test("cheri_capture");
    @(posedge clk_i);
    rst_ni <= 1'b0;
    repeat (3) @(posedge clk_i);
    rst_ni <= 1'b1;
    repeat (100) drive_random(1'b1);
    u_mon.end_test("mid_run_reset");
    u_mon.summary();
    if (u_mon.total_errs == 0 && u_mon.tests_failed == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule
